//--- hdl/int_pkg.sv
`default_nettype none

package int_pkg;

  // operand and result width
  parameter int data_width = 32;

  // exception word
  parameter int exc_width = 8;
  // overflow request on input, overflow report on output
  parameter int exc_pos_ov = 2;

  // one tag per station slot, sized for four slots
  parameter int slot_tag_width = 2;

  typedef enum logic [3:0] {
    nop,
    add,
    sub,
    slt,
    sltu,
    and_op,
    nor_op,
    or_op,
    xor_op,
    sll,
    sra,
    srl,
    clz,
    clo,
    movz,
    movn
  } opgen_e;

  // decoded instruction with resolved operands
  typedef struct packed {
    opgen_e                 opgen;
    logic [exc_width-1:0]   exc_type;
    logic [data_width-1:0]  operand_1;
    logic [data_width-1:0]  operand_2;
  } dispatch_s;

  // station entry on its way to the unit
  typedef struct packed {
    logic [slot_tag_width-1:0] slot;
    dispatch_s                 op;
  } issue_s;

  // unit output, tagged with the slot it came from
  typedef struct packed {
    logic [slot_tag_width-1:0] slot;
    logic                      write_en;
    logic [exc_width-1:0]      exc_type;
    logic [data_width-1:0]     result;
  } result_s;

endpackage

`default_nettype wire

//--- hdl/bit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bit_counter import int_pkg::*; (
  input  wire opgen_e                opgen,
  input  wire [data_width-1:0]       operand,
  output logic [data_width-1:0]      count
);

  logic [data_width-1:0] scan;

  // clo is clz of the inverted word
  assign scan = (opgen == clo) ? ~operand : operand;

  always_comb begin
    logic found;
    found = 1'b0;
    count = '0;
    // msb first, stop at the first set bit
    for (int i = data_width - 1; i >= 0; i--) begin
      if (!found) begin
        if (scan[i]) begin
          found = 1'b1;
        end else begin
          count = count + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/int_unit.sv
`timescale 1ns/1ps
`default_nettype none

module int_unit import int_pkg::*; (
  input  wire issue_s  issue,
  output result_s      result
);

  logic [data_width-1:0] opr_1;
  logic [data_width-1:0] opr_2;
  logic [data_width-1:0] opr_2_mux;
  logic [data_width-1:0] sum;
  logic [data_width-1:0] count;
  logic                  carry_in;
  logic                  negate;
  logic                  overflow;
  logic                  signed_lt;
  logic                  unsigned_lt;
  logic [4:0]            shamt;

  assign opr_1 = issue.op.operand_1;
  assign opr_2 = issue.op.operand_2;
  assign shamt = opr_1[4:0];

  // subtract as op1 + ~op2 + 1
  assign negate    = (issue.op.opgen == sub) || (issue.op.opgen == slt);
  assign opr_2_mux = negate ? ~opr_2 : opr_2;
  assign carry_in  = negate;
  assign sum       = opr_1 + opr_2_mux + {{(data_width-1){1'b0}}, carry_in};

  // same-sign inputs with a sign flip in the sum
  assign overflow = (opr_1[data_width-1] == opr_2_mux[data_width-1]) &&
                    (sum[data_width-1] != opr_1[data_width-1]);

  // sign of the true difference
  assign signed_lt   = sum[data_width-1] ^ overflow;
  assign unsigned_lt = opr_1 < opr_2;

  bit_counter i_bit_counter (
    .opgen   (issue.op.opgen),
    .operand (opr_1),
    .count   (count)
  );

  assign result.slot = issue.slot;

  always_comb begin
    result.exc_type = issue.op.exc_type;
    // overflow only reported when requested
    result.exc_type[exc_pos_ov] = issue.op.exc_type[exc_pos_ov] & overflow;
  end

  always_comb begin
    case (issue.op.opgen)
      nop:     result.write_en = 1'b0;
      movz:    result.write_en = ~|opr_2;
      movn:    result.write_en = |opr_2;
      default: result.write_en = 1'b1;
    endcase
  end

  always_comb begin
    case (issue.op.opgen)
      add, sub:   result.result = sum;
      slt:        result.result = {{(data_width-1){1'b0}}, signed_lt};
      sltu:       result.result = {{(data_width-1){1'b0}}, unsigned_lt};
      and_op:     result.result = opr_1 & opr_2;
      nor_op:     result.result = ~(opr_1 | opr_2);
      or_op:      result.result = opr_1 | opr_2;
      xor_op:     result.result = opr_1 ^ opr_2;
      sll:        result.result = opr_2 << shamt;
      sra:        result.result = $unsigned($signed(opr_2) >>> shamt);
      srl:        result.result = opr_2 >> shamt;
      clz, clo:   result.result = count;
      movz, movn: result.result = opr_1;
      default:    result.result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/int_rs.sv
`timescale 1ns/1ps
`default_nettype none

module int_rs import int_pkg::*; #(
  parameter int rs_slots = 4
) (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire                       dispatch_valid,
  input  wire dispatch_s            dispatch,
  output logic                      dispatch_ready,
  output logic                      issue_valid,
  output issue_s                    issue,
  input  wire                       issue_ready,
  input  wire                       release_valid,
  input  wire [slot_tag_width-1:0]  release_slot
);

  localparam logic [slot_tag_width-1:0] last_slot = slot_tag_width'(rs_slots - 1);

  dispatch_s                 entry_q [rs_slots];
  // busy from allocation until release
  logic [rs_slots-1:0]       busy_q;
  // allocated but not yet issued
  logic [rs_slots-1:0]       pending_q;
  logic [slot_tag_width-1:0] alloc_ptr_q;
  logic [slot_tag_width-1:0] issue_ptr_q;
  logic                      do_alloc;
  logic                      do_issue;

  function automatic logic [slot_tag_width-1:0] next_ptr(
    input logic [slot_tag_width-1:0] ptr
  );
    if (ptr == last_slot) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // slots fill and free in order, so a busy alloc slot means all are busy
  assign dispatch_ready = !busy_q[alloc_ptr_q];
  assign do_alloc       = dispatch_valid && dispatch_ready;

  assign issue_valid = pending_q[issue_ptr_q];
  assign do_issue    = issue_valid && issue_ready;
  assign issue       = '{slot: issue_ptr_q, op: entry_q[issue_ptr_q]};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q      <= '0;
      pending_q   <= '0;
      alloc_ptr_q <= '0;
      issue_ptr_q <= '0;
    end else begin
      if (do_alloc) begin
        busy_q[alloc_ptr_q]    <= 1'b1;
        pending_q[alloc_ptr_q] <= 1'b1;
        alloc_ptr_q            <= next_ptr(alloc_ptr_q);
      end
      if (do_issue) begin
        pending_q[issue_ptr_q] <= 1'b0;
        issue_ptr_q            <= next_ptr(issue_ptr_q);
      end
      // freed slot is never the one being allocated
      if (release_valid) begin
        busy_q[release_slot] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      entry_q[alloc_ptr_q] <= dispatch;
    end
  end

endmodule

`default_nettype wire

//--- hdl/int_wb.sv
`timescale 1ns/1ps
`default_nettype none

module int_wb import int_pkg::*; (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire result_s               in_result,
  input  wire                        issue_valid,
  output logic                       issue_ready,
  output logic                       result_valid,
  output result_s                    result,
  input  wire                        result_ready,
  output logic                       release_valid,
  output logic [slot_tag_width-1:0]  release_slot
);

  logic    held_q;
  result_s held_result_q;

  // take a new result when empty or draining this cycle
  assign issue_ready = !held_q || result_ready;

  assign result_valid = held_q;
  assign result       = held_result_q;

  // hand the slot back as the result leaves
  assign release_valid = held_q && result_ready;
  assign release_slot  = held_result_q.slot;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      held_q <= 1'b0;
    end else if (issue_valid && issue_ready) begin
      held_q <= 1'b1;
    end else if (result_ready) begin
      held_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && issue_ready) begin
      held_result_q <= in_result;
    end
  end

endmodule

`default_nettype wire

//--- hdl/int_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module int_exec_top import int_pkg::*; #(
  parameter int rs_slots = 4
) (
  input  wire             clk,
  input  wire             arst_n,
  input  wire             dispatch_valid,
  input  wire dispatch_s  dispatch,
  output logic            dispatch_ready,
  output logic            result_valid,
  output result_s         result,
  input  wire             result_ready
);

  logic                      issue_valid;
  logic                      issue_ready;
  issue_s                    issue;
  result_s                   unit_result;
  logic                      release_valid;
  logic [slot_tag_width-1:0] release_slot;

  int_rs #(
    .rs_slots (rs_slots)
  ) i_int_rs (
    .clk            (clk),
    .arst_n         (arst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .issue_valid    (issue_valid),
    .issue          (issue),
    .issue_ready    (issue_ready),
    .release_valid  (release_valid),
    .release_slot   (release_slot)
  );

  // combinational between station and writeback
  int_unit i_int_unit (
    .issue  (issue),
    .result (unit_result)
  );

  int_wb i_int_wb (
    .clk           (clk),
    .arst_n        (arst_n),
    .in_result     (unit_result),
    .issue_valid   (issue_valid),
    .issue_ready   (issue_ready),
    .result_valid  (result_valid),
    .result        (result),
    .result_ready  (result_ready),
    .release_valid (release_valid),
    .release_slot  (release_slot)
  );

endmodule

`default_nettype wire

//--- verification/int_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_exec_tb import int_pkg::*; ();

  localparam int slots = 4;
  localparam int clk_period = 100;
  localparam int n_stream = 200;
  // 36 edge pairs and 8 random pairs per op, then tests 2 to 6
  localparam int n_dispatch = 16 * 44 + 8 + 15 + 1 + 5 + n_stream;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        dispatch_valid;
  dispatch_s   dispatch;
  logic        dispatch_ready;
  logic        result_valid;
  result_s     result;
  logic        result_ready;

  integer      seed = 55;
  int          errors = 0;
  int          checks = 0;
  int          next_slot = 0;
  int          first_acc;
  int          first_res;
  dispatch_s   stim_q[$];
  result_s     expect_q[$];
  logic [31:0] edge_val [6] = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
                                32'h7fff_ffff, 32'h1, 32'h1f};

  int_exec_top #(.rs_slots(slots)) i_int_exec_top (.*);

  always #(clk_period / 2) clk = ~clk;

  function automatic void queue_op(opgen_e g, logic [31:0] a, logic [31:0] b, logic [7:0] exc);
    dispatch_s d;
    d = '{opgen: g, exc_type: exc, operand_1: a, operand_2: b};
    stim_q.push_back(d);
  endfunction

  // expected unit output, built from the op rules
  function automatic result_s ref_result(dispatch_s d, logic [1:0] slot);
    result_s     r;
    longint      wide;
    longint      lim;
    logic [31:0] a;
    logic [31:0] b;
    int          n;
    a = d.operand_1;
    b = d.operand_2;
    lim = longint'(1) <<< 31;
    // adder subtracts only for sub and slt
    if (d.opgen == sub || d.opgen == slt) begin
      wide = longint'($signed(a)) - longint'($signed(b));
    end else begin
      wide = longint'($signed(a)) + longint'($signed(b));
    end
    r.slot = slot;
    r.write_en = 1'b1;
    r.exc_type = d.exc_type;
    r.exc_type[exc_pos_ov] = d.exc_type[exc_pos_ov] && (wide >= lim || wide < -lim);
    r.result = '0;
    n = 0;
    case (d.opgen)
      nop:      r.write_en = 1'b0;
      add, sub: r.result = wide[31:0];
      slt:      r.result = {31'b0, $signed(a) < $signed(b)};
      sltu:     r.result = {31'b0, a < b};
      and_op:   r.result = a & b;
      nor_op:   r.result = ~(a | b);
      or_op:    r.result = a | b;
      xor_op:   r.result = a ^ b;
      sll:      r.result = b << a[4:0];
      sra:      r.result = $signed(b) >>> a[4:0];
      srl:      r.result = b >> a[4:0];
      clz, clo: begin
        // leading run of ones for clo, zeros for clz
        while (n < 32 && a[31 - n] == (d.opgen == clo)) begin
          n++;
        end
        r.result = n;
      end
      movz: begin
        r.result = a;
        r.write_en = (b == 0);
      end
      movn: begin
        r.result = a;
        r.write_en = (b != 0);
      end
    endcase
    return r;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic compare_result(result_s got);
    result_s want;
    if (expect_q.size() == 0) begin
      errors++;
      $display("result at %0t arrived with no dispatch left to match it", $time);
    end else begin
      want = expect_q.pop_front();
      check_value("result.slot", got.slot, want.slot);
      check_value("result.write_en", got.write_en, want.write_en);
      check_value("result.exc_type", got.exc_type, want.exc_type);
      check_value("result.result", got.result, want.result);
    end
  endtask

  // drive stim_q in, pop results; ready stays low for the first hold cycles
  task automatic run_stream(int ready_pct, int hold, bit gaps);
    int          sent;
    int          got;
    int          cyc;
    bit          taken;
    logic [31:0] rnd;
    sent = 0;
    got = 0;
    cyc = 0;
    taken = 1'b1;
    first_acc = -1;
    first_res = -1;
    while (got < stim_q.size()) begin
      rnd = $random(seed);
      // payload held until accepted
      if (taken) begin
        dispatch_valid = (sent < stim_q.size()) && !(gaps && rnd[31]);
        if (dispatch_valid) begin
          dispatch = stim_q[sent];
          taken = 1'b0;
        end
      end
      if (hold > 0 && cyc == hold) begin
        check_value("accepted", sent, slots);
        check_value("dispatch_ready", dispatch_ready, 0);
      end
      result_ready = (cyc >= hold) && ((rnd % 100) < ready_pct);
      @(negedge clk);
      if (dispatch_valid && dispatch_ready) begin
        expect_q.push_back(ref_result(stim_q[sent], next_slot[1:0]));
        next_slot = (next_slot + 1) % slots;
        if (sent == 0) begin
          first_acc = cyc;
        end
        sent++;
        taken = 1'b1;
      end
      if (result_valid && result_ready) begin
        if (got == 0) begin
          first_res = cyc;
        end
        compare_result(result);
        got++;
      end
      @(posedge clk);
      #1;
      cyc++;
    end
    dispatch_valid = 1'b0;
    result_ready = 1'b0;
    stim_q.delete();
  endtask

  task automatic test_all_ops();
    for (int g = 0; g < 16; g++) begin
      for (int i = 0; i < 6; i++) begin
        for (int j = 0; j < 6; j++) begin
          queue_op(opgen_e'(g[3:0]), edge_val[i], edge_val[j], 8'($random(seed)));
        end
      end
      repeat (8) queue_op(opgen_e'(g[3:0]), $random(seed), $random(seed), 8'($random(seed)));
    end
    run_stream(100, 0, 1'b0);
    $display("test 1 all ops done, errors %0d", errors);
  endtask

  task automatic test_moves();
    logic [31:0] b_val [4];
    b_val = '{32'h0, 32'h1, 32'hffff_ffff, 32'h0000_8000};
    for (int i = 0; i < 4; i++) begin
      queue_op(movz, $random(seed), b_val[i], 8'h00);
      queue_op(movn, $random(seed), b_val[i], 8'h00);
    end
    run_stream(100, 0, 1'b0);
    $display("test 2 movz movn done, errors %0d", errors);
  endtask

  task automatic test_overflow();
    logic [7:0] exc_val [3];
    exc_val = '{8'hff, 8'hfb, 8'h04};
    for (int i = 0; i < 3; i++) begin
      queue_op(add, 32'h7fff_ffff, 32'h1, exc_val[i]);
      queue_op(add, 32'h8000_0000, 32'hffff_ffff, exc_val[i]);
      queue_op(sub, 32'h8000_0000, 32'h1, exc_val[i]);
      queue_op(sub, 32'h7fff_ffff, 32'hffff_ffff, exc_val[i]);
      queue_op(add, 32'h1, 32'h1, exc_val[i]);
    end
    run_stream(100, 0, 1'b0);
    $display("test 3 overflow done, errors %0d", errors);
  endtask

  task automatic test_latency();
    queue_op(add, 32'd5, 32'd7, 8'h00);
    run_stream(100, 0, 1'b0);
    // acceptance edge plus the writeback edge
    check_value("latency_edges", first_res - first_acc, 2);
    $display("test 4 latency done, errors %0d", errors);
  endtask

  task automatic test_backpressure();
    repeat (5) queue_op(xor_op, $random(seed), $random(seed), 8'h00);
    run_stream(100, 12, 1'b0);
    $display("test 5 back-pressure done, errors %0d", errors);
  endtask

  task automatic test_random_stream();
    logic [31:0] rnd;
    repeat (n_stream) begin
      rnd = $random(seed);
      queue_op(opgen_e'(rnd[3:0]), $random(seed), $random(seed), rnd[15:8]);
    end
    run_stream(60, 0, 1'b1);
    $display("test 6 random stream done, errors %0d", errors);
  endtask

  initial begin
    arst_n = 1'b0;
    dispatch_valid = 1'b0;
    dispatch = '0;
    result_ready = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_value("dispatch_ready", dispatch_ready, 1);
    check_value("result_valid", result_valid, 0);
    test_all_ops();
    test_moves();
    test_overflow();
    test_latency();
    test_backpressure();
    test_random_stream();
    // drained pipe holds no extra result and every slot is free
    repeat (2) @(posedge clk);
    #1;
    check_value("result_valid", result_valid, 0);
    check_value("dispatch_ready", dispatch_ready, 1);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // generous bound per dispatch
  initial begin
    #((n_dispatch * 200 + 100) * clk_period);
    $display("watchdog expired, the pipe stopped delivering results");
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hdl/int_pkg.sv
hdl/bit_counter.sv
hdl/int_unit.sv
hdl/int_rs.sv
hdl/int_wb.sv
hdl/int_exec_top.sv
verification/int_exec_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := int_exec_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -x -F -- "$(PASS_MSG)" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
